/* Makefile */
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_tlb
RTL_TOP   = tlb_top
FILELIST  = verilog.f
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) \
		sv32_pkg.sv tlb_cfg_pkg.sv tlb_array.sv tlb_lookup.sv \
		tlb_perm_check.sv tlb_ctrl.sv tlb_top.sv
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

/* sv32_pkg.sv */
// Sv32 PTE permission bits, access kinds and privilege levels
package sv32_pkg;

    // low byte of an Sv32 PTE
    typedef logic [7:0] pte_perm_t;

    localparam int PTE_V = 0;
    localparam int PTE_R = 1;
    localparam int PTE_W = 2;
    localparam int PTE_X = 3;
    localparam int PTE_U = 4;
    localparam int PTE_G = 5; // global, survives ASID fence
    localparam int PTE_A = 6;
    localparam int PTE_D = 7;

    typedef enum logic [1:0] {
        ACCESS_NONE  = 2'b00,
        ACCESS_LOAD  = 2'b01,
        ACCESS_STORE = 2'b10,
        ACCESS_INSN  = 2'b11
    } access_t;

    // only the modes that translate
    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_S = 2'b01
    } priv_t;

endpackage

/* tb_tlb_ref.svh */
// shadow TLB model with expected PTE, hit or miss, fence effect and page faults
`ifndef TB_TLB_REF_SVH
`define TB_TLB_REF_SVH

logic               sh_valid [N_SETS][ASSOC];
tlb_cfg_pkg::asid_t sh_asid  [N_SETS][ASSOC];
tlb_cfg_pkg::vpn_t  sh_vpn   [N_SETS][ASSOC];
tlb_cfg_pkg::word_t sh_pte   [N_SETS][ASSOC];
int                 sh_last  [N_SETS];  // last used way per set

// walker's page table with global pages in the upper half of the VPN space
function automatic tlb_cfg_pkg::word_t ref_pte(input tlb_cfg_pkg::vpn_t vpn);
    logic [7:0]        perm;
    tlb_cfg_pkg::ppn_t ppn;
    perm    = vpn[7:0] ^ {vpn[11:8], vpn[15:12]} ^ 8'h5b;
    perm[5] = vpn[19];
    ppn     = {2'b01, vpn ^ 20'h3c5a1};
    return {ppn, 2'b00, perm};
endfunction

function automatic logic shadow_lookup(input tlb_cfg_pkg::vpn_t vpn,
                                       input tlb_cfg_pkg::asid_t asid, output int way);
    int s;
    logic found;
    s     = vpn % N_SETS;
    found = 1'b0;
    way   = 0;
    for (int w = ASSOC - 1; w >= 0; w--) begin // lowest way wins
        if (sh_valid[s][w] && sh_asid[s][w] == asid && sh_vpn[s][w] == vpn) begin
            found = 1'b1;
            way   = w;
        end
    end
    return found;
endfunction

function automatic void shadow_fill(input tlb_cfg_pkg::vpn_t vpn, input tlb_cfg_pkg::asid_t asid);
    int s;
    int w;
    s              = vpn % N_SETS;
    w              = (sh_last[s] + 1) % ASSOC; // round robin after last used
    sh_valid[s][w] = 1'b1;
    sh_asid[s][w]  = asid;
    sh_vpn[s][w]   = vpn;
    sh_pte[s][w]   = ref_pte(vpn);
    sh_last[s]     = w;
endfunction

function automatic void shadow_fence(input tlb_cfg_pkg::vpn_t fvpn,
                                     input tlb_cfg_pkg::asid_t fasid);
    for (int s = 0; s < N_SETS; s++) begin
        for (int w = 0; w < ASSOC; w++) begin
            if ((fvpn == '0 || sh_vpn[s][w] == fvpn)
                && (fasid == '0 || (sh_asid[s][w] == fasid && !sh_pte[s][w][5]))) begin
                sh_valid[s][w] = 1'b0;
            end
        end
    end
endfunction

// {insn, store, load}
function automatic logic [2:0] ref_faults(input logic is_store, input tlb_cfg_pkg::word_t pte,
                                          input logic user, input logic s, input logic m);
    logic bad;
    logic pbad;
    bad  = !pte[0] || (pte[2] && !pte[1]);
    pbad = user ? !pte[4] : pte[4] && !s;
    if (is_store) return {1'b0, bad || pbad || !pte[2], 1'b0};
    return {2'b00, bad || pbad || !(pte[1] || (m && pte[3]))};
endfunction

`endif

/* tb_tlb.sv */
// testbench for the Sv32 TLB with walker model, shadow reference and result line
`timescale 1ns/100ps

module tb_tlb;

    localparam int TLB_ENTRIES = 16;
    localparam int ASSOC       = 2;
    localparam int N_SETS      = TLB_ENTRIES / ASSOC;
    localparam int N_REQUESTS  = 74;
    localparam int N_FENCES    = 3;
    localparam int CYCLE_LIMIT = 40 * N_REQUESTS + 2 * TLB_ENTRIES * N_FENCES + 10 + TLB_ENTRIES;

    logic CLK = 1'b0;
    logic nRST;
    logic req_ren, req_wen, sum, mxr, trans_on;
    tlb_cfg_pkg::word_t req_va, hit_pte, walk_addr, walk_rdata, fence_va;
    tlb_cfg_pkg::asid_t satp_asid, fence_asid;
    sv32_pkg::priv_t    priv;
    logic busy, tlb_miss, fault_load_page, fault_store_page, fault_insn_page;
    logic walk_ren, walk_busy, walk_error, page_fault, fence, fence_done;

    integer seed = 32'h3d0c_4675;
    int     errors = 0;
    int     checks = 0;
    int     test_base = 0;
    int     cycle_count = 0;
    int     inject_mode = 0; // 0 normal reply, 1 walk error, 2 page fault

    `include "tb_tlb_ref.svh"

    tlb_top #(.TLB_ENTRIES(TLB_ENTRIES), .TLB_ASSOC(ASSOC), .IS_ITLB(0)) dut (.*);

    always #5 CLK = ~CLK;

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    // walker answers 1 to 4 cycles after it sees the request
    always begin
        int delay;
        @(posedge CLK);
        if (walk_ren) begin
            @(negedge CLK);
            walk_busy = 1'b1;
            delay     = 1 + {$random(seed)} % 4;
            repeat (delay) @(negedge CLK);
            if (inject_mode == 1) walk_error = 1'b1;
            else if (inject_mode == 2) page_fault = 1'b1;
            else begin
                walk_rdata = ref_pte(walk_addr[31:12]);
                walk_busy  = 1'b0;
            end
            @(negedge CLK);
            walk_busy  = 1'b0;
            walk_error = 1'b0;
            page_fault = 1'b0;
        end
    end

    task automatic do_access(input tlb_cfg_pkg::vpn_t vpn, input tlb_cfg_pkg::asid_t asid,
                             input logic is_store, input logic user, input logic s,
                             input logic m, input int inject);
        logic exp_hit;
        logic done;
        logic aborted;
        int   way;
        int   cycles;
        exp_hit = shadow_lookup(vpn, asid, way);
        @(negedge CLK);
        req_ren     = !is_store;
        req_wen     = is_store;
        req_va      = {vpn, 12'($random(seed))};
        satp_asid   = asid;
        priv        = user ? sv32_pkg::PRIV_U : sv32_pkg::PRIV_S;
        sum         = s;
        mxr         = m;
        trans_on    = 1'b1;
        inject_mode = inject;
        #1;
        check_val("tlb_miss", tlb_miss, !exp_hit);
        check_val("walk_ren", walk_ren, !exp_hit);
        if (!exp_hit) check_val("walk_addr", walk_addr, req_va);
        done    = 1'b0;
        aborted = 1'b0;
        cycles  = 0;
        while (!done) begin
            if (!busy) begin
                check_val("hit_pte", hit_pte, ref_pte(vpn));
                check_val("faults", {fault_insn_page, fault_store_page, fault_load_page},
                          ref_faults(is_store, ref_pte(vpn), user, s, m));
                done = 1'b1;
            end else if (walk_error || page_fault) begin
                aborted = 1'b1;
                done    = 1'b1;
            end else if (cycles > 40) begin
                errors++;
                $display("request for page %h got no answer within 40 cycles", vpn);
                done = 1'b1;
            end
            if (!done) begin
                @(negedge CLK);
                #1;
                cycles++;
            end
        end
        if (exp_hit) sh_last[vpn % N_SETS] = way;
        else if (!aborted) shadow_fill(vpn, asid);
        @(negedge CLK);
        req_ren     = 1'b0;
        req_wen     = 1'b0;
        inject_mode = 0;
    endtask

    task automatic do_fence(input tlb_cfg_pkg::vpn_t vpn, input tlb_cfg_pkg::asid_t asid);
        int   cycles;
        logic seen;
        @(negedge CLK);
        fence      = 1'b1;
        fence_va   = {vpn, 12'h000};
        fence_asid = asid;
        cycles     = 0;
        seen       = 1'b0;
        while (!seen && cycles <= 2 * TLB_ENTRIES) begin
            @(negedge CLK);
            fence = 1'b0;
            #1;
            cycles++;
            seen = fence_done;
        end
        if (!seen) begin
            errors++;
            $display("fence_done never pulsed after the fence");
        end else check_val("fence_cycles", cycles, TLB_ENTRIES + 1);
        @(negedge CLK);
        #1;
        check_val("fence_done", fence_done, 1'b0); // one cycle only
        shadow_fence(vpn, asid);
    endtask

    always @(posedge CLK) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run stopped, exceeded %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        int cycles;
        logic [31:0] r;
        nRST = 1'b0;
        {req_ren, req_wen, sum, mxr, trans_on, fence} = '0;
        {walk_busy, walk_error, page_fault} = '0;
        req_va     = '0;
        walk_rdata = '0;
        fence_va   = '0;
        satp_asid  = '0;
        fence_asid = '0;
        priv = sv32_pkg::PRIV_S;
        for (int s = 0; s < N_SETS; s++) begin
            sh_last[s] = 0;
            for (int w = 0; w < ASSOC; w++) sh_valid[s][w] = 1'b0;
        end
        repeat (10) @(negedge CLK);
        #1;
        check_val("busy", busy, 1'b1);
        check_val("reset_outs", {tlb_miss, walk_ren, fence_done}, 3'b000);
        check_val("reset_faults", {fault_insn_page, fault_store_page, fault_load_page}, 3'b000);
        nRST   = 1'b1;
        cycles = 0;
        while (busy && cycles < 2 * TLB_ENTRIES) begin
            @(negedge CLK);
            #1;
            cycles++;
        end
        check_val("init_cycles", cycles, TLB_ENTRIES);
        for (int i = 0; i < 8; i++) do_access(20'h00100 + i % 4, 9'd1, 1'b0, 1'b0, 1'b0, 1'b0, 0);
        end_test("init_miss_fill");

        for (int i = 0; i < 4; i++) do_access(20'h00100 + i, 9'd1, 1'b1, 1'b0, 1'b1, 1'b0, 0);
        do_access(20'h00100, 9'd2, 1'b0, 1'b0, 1'b0, 1'b0, 0); // other address space
        end_test("rehit_asid");

        do_access(20'h00205, 9'd1, 1'b0, 1'b0, 1'b0, 1'b0, 0);
        do_access(20'h0020d, 9'd1, 1'b0, 1'b0, 1'b0, 1'b0, 0);
        do_access(20'h00215, 9'd1, 1'b0, 1'b0, 1'b0, 1'b0, 0);
        do_access(20'h00205, 9'd1, 1'b0, 1'b0, 1'b0, 1'b0, 0);
        do_access(20'h0020d, 9'd1, 1'b0, 1'b0, 1'b0, 1'b0, 0);
        end_test("replacement");

        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            do_access({r[6], 13'h0, r[5:0]}, 9'd1, r[7], r[8], r[9], r[10], 0);
        end
        end_test("permissions");

        do_access(20'h80011, 9'd1, 1'b0, 1'b0, 1'b0, 1'b0, 0); // global
        do_access(20'h00011, 9'd1, 1'b0, 1'b0, 1'b0, 1'b0, 0);
        do_access(20'h00012, 9'd2, 1'b0, 1'b0, 1'b0, 1'b0, 0);
        do_fence(20'h00000, 9'd1);
        do_access(20'h80011, 9'd1, 1'b0, 1'b0, 1'b0, 1'b0, 0);
        do_access(20'h00011, 9'd1, 1'b0, 1'b0, 1'b0, 1'b0, 0);
        do_access(20'h00012, 9'd2, 1'b0, 1'b0, 1'b0, 1'b0, 0);
        do_fence(20'h00012, 9'd0);
        do_access(20'h00012, 9'd2, 1'b0, 1'b0, 1'b0, 1'b0, 0);
        do_access(20'h00011, 9'd1, 1'b0, 1'b0, 1'b0, 1'b0, 0);
        do_access(20'h80011, 9'd1, 1'b0, 1'b0, 1'b0, 1'b0, 0);
        do_fence(20'h00000, 9'd0);
        do_access(20'h80011, 9'd1, 1'b0, 1'b0, 1'b0, 1'b0, 0);
        do_access(20'h00011, 9'd1, 1'b0, 1'b0, 1'b0, 1'b0, 0);
        do_access(20'h00012, 9'd2, 1'b0, 1'b0, 1'b0, 1'b0, 0);
        end_test("fences");

        do_access(20'h00306, 9'd1, 1'b0, 1'b0, 1'b0, 1'b0, 1);
        do_access(20'h00306, 9'd1, 1'b0, 1'b0, 1'b0, 1'b0, 0);
        do_access(20'h00307, 9'd1, 1'b1, 1'b0, 1'b0, 1'b0, 2);
        do_access(20'h00307, 9'd1, 1'b1, 1'b0, 1'b0, 1'b0, 0);
        end_test("walk_abort");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* tlb_array.sv */
// set-indexed TLB storage with masked synchronous write and asynchronous read
`timescale 1ns/100ps

module tlb_array #(
    parameter int TLB_ENTRIES = 16,
    parameter int TLB_ASSOC   = 2,
    localparam int N_SETS  = TLB_ENTRIES / TLB_ASSOC,
    localparam int SET_W   = $clog2(N_SETS) + (N_SETS == 1),
    localparam int TAG_W   = tlb_cfg_pkg::VPN_BITS - SET_W,
    localparam int FRAME_W = 1 + tlb_cfg_pkg::ASID_BITS + TAG_W + tlb_cfg_pkg::WORD_BITS
) (
    input  logic                              CLK,
    input  logic                              nRST,
    input  logic [SET_W-1:0]                  sel,
    input  logic                              wen,
    input  logic [TLB_ASSOC-1:0][FRAME_W-1:0] wdata,
    input  logic [TLB_ASSOC-1:0][FRAME_W-1:0] wmask,
    output logic [TLB_ASSOC-1:0][FRAME_W-1:0] rdata
);

    // frame layout {valid, asid, tag, pte}
    logic [TLB_ASSOC-1:0][FRAME_W-1:0] mem [N_SETS];

    // mask bit set means keep the stored bit
    always_ff @(posedge CLK) begin
        if (wen) begin
            mem[sel] <= (mem[sel] & wmask) | (wdata & ~wmask);
        end
    end

    assign rdata = mem[sel]; // combinational read

    // controller must never address past the last set
    a_sel_range: assert property (@(posedge CLK) disable iff (!nRST)
        wen |-> (!$isunknown(sel) && (int'(sel) < N_SETS)));

endmodule

/* tlb_cfg_pkg.sv */
// address geometry widths and vector types for word, VPN, PPN, ASID and page offset
package tlb_cfg_pkg;

    localparam int WORD_BITS        = 32;
    localparam int PAGE_OFFSET_BITS = 12; // 4 KiB pages
    localparam int VPN_BITS         = WORD_BITS - PAGE_OFFSET_BITS;
    localparam int PPN_BITS         = 22;
    localparam int ASID_BITS        = 9;

    typedef logic [WORD_BITS-1:0]        word_t;
    typedef logic [VPN_BITS-1:0]         vpn_t;
    typedef logic [PPN_BITS-1:0]         ppn_t;
    typedef logic [ASID_BITS-1:0]        asid_t;
    typedef logic [PAGE_OFFSET_BITS-1:0] offset_t;

endpackage

/* tlb_ctrl.sv */
// TLB control FSM for init clear, hit, page walk fill and fence sweep
`timescale 1ns/100ps

module tlb_ctrl #(
    parameter int TLB_ENTRIES = 16,
    parameter int TLB_ASSOC   = 2,
    parameter int IS_ITLB     = 0,
    localparam int N_SETS  = TLB_ENTRIES / TLB_ASSOC,
    localparam int SET_W   = $clog2(N_SETS) + (N_SETS == 1),
    localparam int WAY_W   = $clog2(TLB_ASSOC) + (TLB_ASSOC == 1),
    localparam int TAG_W   = tlb_cfg_pkg::VPN_BITS - SET_W,
    localparam int FRAME_W = 1 + tlb_cfg_pkg::ASID_BITS + TAG_W + tlb_cfg_pkg::WORD_BITS
) (
    input  logic                              CLK,
    input  logic                              nRST,
    input  logic                              req_ren,
    input  logic                              req_wen,
    input  tlb_cfg_pkg::word_t                req_va,
    input  tlb_cfg_pkg::asid_t                satp_asid,
    input  logic                              trans_on,
    input  logic                              fence,
    input  tlb_cfg_pkg::word_t                fence_va,
    input  tlb_cfg_pkg::asid_t                fence_asid,
    input  logic                              page_fault,
    input  logic                              hit,
    input  logic [WAY_W-1:0]                  hit_way,
    input  tlb_cfg_pkg::word_t                hit_pte,
    input  logic [WAY_W-1:0]                  repl_way,
    input  logic [TLB_ASSOC-1:0][FRAME_W-1:0] rdata,
    input  logic                              walk_busy,
    input  tlb_cfg_pkg::word_t                walk_rdata,
    input  logic                              walk_error,
    output logic [SET_W-1:0]                  sel,
    output logic                              wen,
    output logic [TLB_ASSOC-1:0][FRAME_W-1:0] wdata,
    output logic [TLB_ASSOC-1:0][FRAME_W-1:0] wmask,
    output logic                              touch,
    output logic [WAY_W-1:0]                  touch_way,
    output logic                              busy,
    output logic                              tlb_miss,
    output logic                              walk_ren,
    output tlb_cfg_pkg::word_t                walk_addr,
    output logic                              fence_done,
    output logic                              check,
    output sv32_pkg::access_t                 access
);

    localparam int WORD_BITS = tlb_cfg_pkg::WORD_BITS;
    localparam int ASID_BITS = tlb_cfg_pkg::ASID_BITS;
    localparam int OFF_BITS  = tlb_cfg_pkg::PAGE_OFFSET_BITS;

    typedef enum logic [1:0] {INIT, READY, FETCH, FENCE} state_t;

    state_t               state, next_state;
    logic [SET_W-1:0]     sweep_set;
    logic [WAY_W-1:0]     sweep_way;
    logic                 sweep_fin;  // all ways visited so done pulses next
    logic                 sweep_step;
    logic                 sweep_last;
    logic [FRAME_W-1:0]   sweep_frame;
    tlb_cfg_pkg::vpn_t    sweep_vpn;
    tlb_cfg_pkg::vpn_t    req_vpn;
    tlb_cfg_pkg::vpn_t    miss_vpn;
    tlb_cfg_pkg::offset_t miss_off;
    logic                 latch_miss;
    logic                 req;
    logic                 va_match;
    logic                 asid_match;

    assign req     = req_ren || req_wen;
    assign req_vpn = req_va[WORD_BITS-1:OFF_BITS];

    generate
        if (IS_ITLB != 0) begin : g_itlb
            assign access = sv32_pkg::ACCESS_INSN;
        end else begin : g_dtlb
            assign access = req_wen ? sv32_pkg::ACCESS_STORE :
                            req_ren ? sv32_pkg::ACCESS_LOAD : sv32_pkg::ACCESS_NONE;
        end
    endgenerate

    assign sweep_last  = (sweep_set == SET_W'(N_SETS - 1))
                         && (sweep_way == WAY_W'(TLB_ASSOC - 1));
    assign sweep_frame = rdata[sweep_way];
    assign sweep_vpn   = {sweep_frame[WORD_BITS +: TAG_W], sweep_set};

    // zero selector means "any"
    assign va_match   = (fence_va == '0) || (sweep_vpn == fence_va[WORD_BITS-1:OFF_BITS]);
    assign asid_match = (fence_asid == '0)
                        || ((sweep_frame[FRAME_W-2 -: ASID_BITS] == fence_asid)
                            && !sweep_frame[sv32_pkg::PTE_G]);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= INIT;
            sweep_set <= '0;
            sweep_way <= '0;
            sweep_fin <= 1'b0;
        end else begin
            state <= next_state;
            if (sweep_step) begin
                if (sweep_last) begin
                    sweep_set <= '0;
                    sweep_way <= '0;
                    sweep_fin <= (state == FENCE); // init goes straight to READY
                end else if (sweep_way == WAY_W'(TLB_ASSOC - 1)) begin
                    sweep_set <= sweep_set + 1'b1;
                    sweep_way <= '0;
                end else begin
                    sweep_way <= sweep_way + 1'b1;
                end
            end
            if (fence_done) begin
                sweep_fin <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (latch_miss) begin
            miss_vpn <= req_vpn;
            miss_off <= req_va[OFF_BITS-1:0];
        end
    end

    always_comb begin
        next_state = state;
        sel        = req_vpn[SET_W-1:0];
        wen        = 1'b0;
        wdata      = '0;
        wmask      = '1;
        touch      = 1'b0;
        touch_way  = hit_way;
        busy       = 1'b1;
        tlb_miss   = 1'b0;
        walk_ren   = 1'b0;
        walk_addr  = {miss_vpn, miss_off};
        fence_done = 1'b0;
        check      = 1'b0;
        sweep_step = 1'b0;
        latch_miss = 1'b0;
        case (state)
            INIT: begin
                sel                = sweep_set; // one way cleared per cycle
                wen                = 1'b1;
                wmask[sweep_way]   = '0;
                sweep_step         = 1'b1;
                if (sweep_last) begin
                    next_state = READY;
                end
            end
            READY: begin
                if (fence) begin
                    tlb_miss   = 1'b1;
                    next_state = FENCE;
                end else if (!trans_on) begin
                    busy = 1'b0; // bare mode has nothing to translate
                end else if (req && hit) begin
                    busy  = 1'b0;
                    check = 1'b1;
                    touch = 1'b1;
                end else if (req) begin
                    tlb_miss   = 1'b1;
                    walk_ren   = 1'b1;
                    walk_addr  = req_va;
                    latch_miss = 1'b1;
                    next_state = FETCH;
                end
            end
            FETCH: begin
                sel      = miss_vpn[SET_W-1:0];
                tlb_miss = 1'b1;
                walk_ren = 1'b1;
                if (walk_error || page_fault) begin
                    next_state = READY; // abandoned walk leaves no fill
                end else if (!walk_busy) begin
                    wen              = 1'b1;
                    wmask[repl_way]  = '0;
                    wdata[repl_way]  = {1'b1, satp_asid, miss_vpn[tlb_cfg_pkg::VPN_BITS-1:SET_W],
                                        walk_rdata};
                    touch            = 1'b1;
                    touch_way        = repl_way;
                    next_state       = READY;
                end
            end
            FENCE: begin
                sel      = sweep_set;
                tlb_miss = 1'b1;
                if (sweep_fin) begin
                    fence_done = 1'b1;
                    next_state = READY;
                end else begin
                    sweep_step = 1'b1;
                    if (sweep_frame[FRAME_W-1] && va_match && asid_match) begin
                        wen              = 1'b1;
                        wmask[sweep_way] = '0;
                    end
                end
            end
            default: next_state = INIT;
        endcase
    end

    // the walker sees one address for the whole walk
    a_walk_addr_held: assert property (@(posedge CLK) disable iff (!nRST)
        (walk_ren && state == FETCH) |-> (walk_addr == $past(walk_addr)));

    // held request hits the entry just filled
    a_fill_hit: assert property (@(posedge CLK) disable iff (!nRST)
        ($past(state == FETCH && wen) && check) |-> (hit_pte == $past(walk_rdata)));

endmodule

/* tlb_lookup.sv */
// tag and ASID compare across ways, hit select and per-set round-robin pointer
`timescale 1ns/100ps

module tlb_lookup #(
    parameter int TLB_ENTRIES = 16,
    parameter int TLB_ASSOC   = 2,
    localparam int N_SETS  = TLB_ENTRIES / TLB_ASSOC,
    localparam int SET_W   = $clog2(N_SETS) + (N_SETS == 1),
    localparam int WAY_W   = $clog2(TLB_ASSOC) + (TLB_ASSOC == 1),
    localparam int TAG_W   = tlb_cfg_pkg::VPN_BITS - SET_W,
    localparam int FRAME_W = 1 + tlb_cfg_pkg::ASID_BITS + TAG_W + tlb_cfg_pkg::WORD_BITS
) (
    input  logic                              CLK,
    input  logic                              nRST,
    input  logic [TLB_ASSOC-1:0][FRAME_W-1:0] rdata,
    input  tlb_cfg_pkg::word_t                req_va,
    input  tlb_cfg_pkg::asid_t                satp_asid,
    input  logic                              enable,
    input  logic                              touch,
    input  logic [WAY_W-1:0]                  touch_way,
    output logic                              hit,
    output logic [WAY_W-1:0]                  hit_way,
    output tlb_cfg_pkg::word_t                hit_pte,
    output logic [WAY_W-1:0]                  repl_way
);

    localparam int WORD_BITS = tlb_cfg_pkg::WORD_BITS;
    localparam int ASID_BITS = tlb_cfg_pkg::ASID_BITS;

    logic [TLB_ASSOC-1:0] match;
    logic [SET_W-1:0]     set_idx;
    logic [TAG_W-1:0]     req_tag;
    logic [WAY_W-1:0]     last_used [N_SETS]; // most recently used way per set
    logic [WAY_W-1:0]     last;

    assign set_idx = req_va[tlb_cfg_pkg::PAGE_OFFSET_BITS +: SET_W];
    assign req_tag = req_va[WORD_BITS-1 -: TAG_W];

    always_comb begin
        for (int i = 0; i < TLB_ASSOC; i++) begin
            match[i] = enable && rdata[i][FRAME_W-1]
                       && (rdata[i][FRAME_W-2 -: ASID_BITS] == satp_asid)
                       && (rdata[i][WORD_BITS +: TAG_W] == req_tag);
        end
    end

    // walk downward so the lowest matching way wins
    always_comb begin
        hit     = |match;
        hit_way = '0;
        hit_pte = '0;
        for (int i = TLB_ASSOC - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_way = WAY_W'(i);
                hit_pte = rdata[i][WORD_BITS-1:0];
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < N_SETS; s++) begin
                last_used[s] <= '0;
            end
        end else if (touch) begin
            last_used[set_idx] <= touch_way; // hit or fill
        end
    end

    assign last     = last_used[set_idx];
    assign repl_way = (last == WAY_W'(TLB_ASSOC - 1)) ? '0 : last + 1'b1;

    // fills and fences should never leave duplicates behind
    a_single_match: assert property (@(posedge CLK) disable iff (!nRST) $onehot0(match));

endmodule

/* tlb_perm_check.sv */
// Sv32 leaf permission check producing load, store and fetch page faults
`timescale 1ns/100ps

module tlb_perm_check (
    input  logic                check,
    input  sv32_pkg::access_t   access,
    input  tlb_cfg_pkg::word_t  pte,
    input  sv32_pkg::priv_t     priv,
    input  logic                sum,
    input  logic                mxr,
    output logic                fault_load_page,
    output logic                fault_store_page,
    output logic                fault_insn_page
);

    sv32_pkg::pte_perm_t perm;
    logic bad_pte;
    logic priv_bad;
    logic can_read;

    assign perm = pte[$bits(sv32_pkg::pte_perm_t)-1:0];

    // invalid, or the reserved W-without-R encoding
    assign bad_pte  = !perm[sv32_pkg::PTE_V] || (perm[sv32_pkg::PTE_W] && !perm[sv32_pkg::PTE_R]);
    assign can_read = perm[sv32_pkg::PTE_R] || (mxr && perm[sv32_pkg::PTE_X]); // MXR

    always_comb begin
        if (priv == sv32_pkg::PRIV_U) begin
            priv_bad = !perm[sv32_pkg::PTE_U];
        end else begin
            // supervisor never fetches from user pages
            priv_bad = perm[sv32_pkg::PTE_U] && ((access == sv32_pkg::ACCESS_INSN) || !sum);
        end
    end

    assign fault_load_page  = check && (access == sv32_pkg::ACCESS_LOAD)
                              && (bad_pte || priv_bad || !can_read);
    assign fault_store_page = check && (access == sv32_pkg::ACCESS_STORE)
                              && (bad_pte || priv_bad || !perm[sv32_pkg::PTE_W]);
    assign fault_insn_page  = check && (access == sv32_pkg::ACCESS_INSN)
                              && (bad_pte || priv_bad || !perm[sv32_pkg::PTE_X]);

endmodule

/* tlb_top.sv */
// TLB top level wiring controller, storage, lookup and permission check
`timescale 1ns/100ps

module tlb_top #(
    parameter int TLB_ENTRIES = 16,
    parameter int TLB_ASSOC   = 2,
    parameter int IS_ITLB     = 0
) (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                req_ren,
    input  logic                req_wen,
    input  tlb_cfg_pkg::word_t  req_va,
    input  tlb_cfg_pkg::asid_t  satp_asid,
    input  sv32_pkg::priv_t     priv,
    input  logic                sum,
    input  logic                mxr,
    input  logic                trans_on,
    output logic                busy,
    output logic                tlb_miss,
    output tlb_cfg_pkg::word_t  hit_pte,
    output logic                fault_load_page,
    output logic                fault_store_page,
    output logic                fault_insn_page,
    output logic                walk_ren,
    output tlb_cfg_pkg::word_t  walk_addr,
    input  logic                walk_busy,
    input  tlb_cfg_pkg::word_t  walk_rdata,
    input  logic                walk_error,
    input  logic                page_fault,
    input  logic                fence,
    input  tlb_cfg_pkg::word_t  fence_va,
    input  tlb_cfg_pkg::asid_t  fence_asid,
    output logic                fence_done
);

    localparam int N_SETS  = TLB_ENTRIES / TLB_ASSOC;
    localparam int SET_W   = $clog2(N_SETS) + (N_SETS == 1);
    localparam int WAY_W   = $clog2(TLB_ASSOC) + (TLB_ASSOC == 1);
    localparam int TAG_W   = tlb_cfg_pkg::VPN_BITS - SET_W;
    localparam int FRAME_W = 1 + tlb_cfg_pkg::ASID_BITS + TAG_W + tlb_cfg_pkg::WORD_BITS;

    logic [SET_W-1:0]                  sel;
    logic                              wen;
    logic [TLB_ASSOC-1:0][FRAME_W-1:0] wdata;
    logic [TLB_ASSOC-1:0][FRAME_W-1:0] wmask;
    logic [TLB_ASSOC-1:0][FRAME_W-1:0] rdata;
    logic                              hit;
    logic [WAY_W-1:0]                  hit_way;
    logic [WAY_W-1:0]                  repl_way;
    logic                              touch;
    logic [WAY_W-1:0]                  touch_way;
    logic                              check;
    sv32_pkg::access_t                 access;

    tlb_ctrl #(.TLB_ENTRIES(TLB_ENTRIES), .TLB_ASSOC(TLB_ASSOC), .IS_ITLB(IS_ITLB)) u_ctrl (
        .CLK(CLK), .nRST(nRST),
        .req_ren(req_ren), .req_wen(req_wen), .req_va(req_va), .satp_asid(satp_asid),
        .trans_on(trans_on), .fence(fence), .fence_va(fence_va), .fence_asid(fence_asid),
        .page_fault(page_fault), .hit(hit), .hit_way(hit_way), .hit_pte(hit_pte),
        .repl_way(repl_way), .rdata(rdata), .walk_busy(walk_busy), .walk_rdata(walk_rdata),
        .walk_error(walk_error), .sel(sel), .wen(wen), .wdata(wdata), .wmask(wmask),
        .touch(touch), .touch_way(touch_way), .busy(busy), .tlb_miss(tlb_miss),
        .walk_ren(walk_ren), .walk_addr(walk_addr), .fence_done(fence_done),
        .check(check), .access(access)
    );

    tlb_array #(.TLB_ENTRIES(TLB_ENTRIES), .TLB_ASSOC(TLB_ASSOC)) u_array (
        .CLK(CLK), .nRST(nRST), .sel(sel), .wen(wen),
        .wdata(wdata), .wmask(wmask), .rdata(rdata)
    );

    // lookups only count with translation on
    tlb_lookup #(.TLB_ENTRIES(TLB_ENTRIES), .TLB_ASSOC(TLB_ASSOC)) u_lookup (
        .CLK(CLK), .nRST(nRST), .rdata(rdata), .req_va(req_va), .satp_asid(satp_asid),
        .enable(trans_on), .touch(touch), .touch_way(touch_way),
        .hit(hit), .hit_way(hit_way), .hit_pte(hit_pte), .repl_way(repl_way)
    );

    tlb_perm_check u_perm (
        .check(check), .access(access), .pte(hit_pte), .priv(priv), .sum(sum), .mxr(mxr),
        .fault_load_page(fault_load_page), .fault_store_page(fault_store_page),
        .fault_insn_page(fault_insn_page)
    );

endmodule

/* verilog.f */
sv32_pkg.sv
tlb_cfg_pkg.sv
tlb_array.sv
tlb_lookup.sv
tlb_perm_check.sv
tlb_ctrl.sv
tlb_top.sv
+incdir+.
tb_tlb.sv
